//--- hw/spi_params.svh
/* SPI master configuration
   SCK ratio, frame delays and FIFO depth */

`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

`default_nettype none

// aclk cycles per SCK period, even and at least 2
`define SPI_CLK_RATIO   8

// aclk cycles from ss_n falling to the first SCK edge of the frame
`define SPI_PRE_CYCLES  4

// aclk cycles after the last SCK falling edge before ss_n rises
`define SPI_POST_CYCLES 4

// Default depth of the transmit and receive FIFOs
`define SPI_FIFO_DEPTH  4

`default_nettype wire

`endif

//--- hw/spi_pkg.sv
/* Shared types of the SPI master
   Data byte, tick counter, pin bundle and engine states */

`include "spi_params.svh"
`default_nettype none

package spi_pkg;

    // Longest interval the tick counter has to cover
    localparam int SPI_CNT_MAX =
        (`SPI_CLK_RATIO >= `SPI_PRE_CYCLES && `SPI_CLK_RATIO >= `SPI_POST_CYCLES) ?
            `SPI_CLK_RATIO :
        (`SPI_PRE_CYCLES >= `SPI_POST_CYCLES) ? `SPI_PRE_CYCLES : `SPI_POST_CYCLES;
    localparam int SPI_CNT_W = $clog2(SPI_CNT_MAX + 1);

    typedef logic [7:0] spi_byte_t;

    typedef logic [SPI_CNT_W-1:0] spi_cnt_t;

    // Pins driven by the master, always enabled
    typedef struct packed {
        logic sck;
        logic ss_n;
        logic mosi;
    } spi_pins_t;

    typedef enum logic [1:0] {
        IDLE,
        PRE,
        SHIFT,
        POST
    } spi_state_e;

endpackage

`default_nettype wire

//--- hw/byte_fifo.sv
/* Byte FIFO, first-word fall-through
   Circular buffer with valid/ready on both sides */

`timescale 1ns/1ns
`include "spi_params.svh"
`default_nettype none

module byte_fifo
    import spi_pkg::*;
#(
    parameter int DEPTH = `SPI_FIFO_DEPTH
) (
    input  logic      aclk,
    input  logic      aresetn,
    input  spi_byte_t in_data,
    input  logic      in_valid,
    output logic      in_ready,
    output spi_byte_t out_data,
    output logic      out_valid,
    input  logic      out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    spi_byte_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    // Pointer wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/spi_shift_engine.sv
/* SPI mode 0 shift engine
   Runs one slave-select frame per byte and returns the byte read on MISO */

`timescale 1ns/1ns
`include "spi_params.svh"
`default_nettype none

module spi_shift_engine
    import spi_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    input  spi_byte_t tx_data,
    input  logic      tx_valid,
    output logic      tx_ready,
    output spi_byte_t rx_data,
    output logic      rx_valid,
    input  logic      rx_ready,
    output spi_pins_t spi,
    input  logic      miso
);

    // Last tick of a half SCK period, of PRE and of POST
    localparam spi_cnt_t HALF_LAST = spi_cnt_t'(`SPI_CLK_RATIO / 2 - 1);
    localparam spi_cnt_t PRE_LAST  = spi_cnt_t'(`SPI_PRE_CYCLES - 1);
    localparam spi_cnt_t POST_LAST = spi_cnt_t'(`SPI_POST_CYCLES - 1);

    spi_state_e state;
    spi_cnt_t   tick_cnt;
    logic [2:0] bit_cnt;
    spi_pins_t  pins_q;
    logic [6:0] tx_rest;
    spi_byte_t  rx_shift;
    logic       rx_valid_q;
    logic       accept;
    logic       half_done;
    logic       sck_rise;
    logic       sck_fall;

    // ------------------------------------------------------------------------
    // Stream handshakes
    // ------------------------------------------------------------------------

    // Room for the returned byte is required before a frame starts,
    // so the previous byte must already be in the receive FIFO
    assign tx_ready = (state == IDLE) && rx_ready && !rx_valid_q;
    assign accept   = tx_valid && tx_ready;

    assign rx_data  = rx_shift;
    assign rx_valid = rx_valid_q;
    assign spi      = pins_q;

    // SCK edges happen at the end of each half period
    assign half_done = (state == SHIFT) && (tick_cnt == HALF_LAST);
    assign sck_rise  = half_done && !pins_q.sck;
    assign sck_fall  = half_done && pins_q.sck;

    // ------------------------------------------------------------------------
    // Frame FSM and pin registers
    // ------------------------------------------------------------------------

    // ss_n low for PRE + 8 * RATIO + POST cycles per frame
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state      <= IDLE;
            tick_cnt   <= '0;
            bit_cnt    <= '0;
            pins_q     <= '{sck: 1'b0, ss_n: 1'b1, mosi: 1'b0};
            rx_valid_q <= 1'b0;
        end else begin
            if (rx_valid_q && rx_ready) begin
                rx_valid_q <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (accept) begin
                        state       <= PRE;
                        tick_cnt    <= '0;
                        pins_q.ss_n <= 1'b0;
                        // MSB set up for the whole pre-delay
                        pins_q.mosi <= tx_data[7];
                    end
                end
                PRE: begin
                    if (tick_cnt == PRE_LAST) begin
                        state    <= SHIFT;
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                SHIFT: begin
                    if (half_done) begin
                        tick_cnt   <= '0;
                        pins_q.sck <= !pins_q.sck;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    // Falling edge ends a bit, next bit goes out with it
                    if (sck_fall) begin
                        if (bit_cnt == 3'd7) begin
                            state <= POST;
                        end else begin
                            bit_cnt     <= bit_cnt + 1'b1;
                            pins_q.mosi <= tx_rest[6];
                        end
                    end
                end
                POST: begin
                    if (tick_cnt == POST_LAST) begin
                        state       <= IDLE;
                        tick_cnt    <= '0;
                        pins_q.ss_n <= 1'b1;
                        pins_q.mosi <= 1'b0;
                        rx_valid_q  <= 1'b1;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Data shift registers
    // ------------------------------------------------------------------------

    // Remaining transmit bits after the MSB
    always_ff @(posedge aclk) begin
        if (accept) begin
            tx_rest <= tx_data[6:0];
        end else if (sck_fall) begin
            tx_rest <= {tx_rest[5:0], 1'b0};
        end
    end

    // MISO captured as SCK goes high, MSB first
    always_ff @(posedge aclk) begin
        if (sck_rise) begin
            rx_shift <= {rx_shift[6:0], miso};
        end
    end

endmodule

`default_nettype wire

//--- hw/spi_master_sub.sv
/* SPI master subsystem top
   Transmit FIFO, shift engine and receive FIFO in series */

`timescale 1ns/1ns
`include "spi_params.svh"
`default_nettype none

module spi_master_sub
    import spi_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    input  spi_byte_t tx_data,
    input  logic      tx_valid,
    output logic      tx_ready,
    output spi_byte_t rx_data,
    output logic      rx_valid,
    input  logic      rx_ready,
    output spi_pins_t spi,
    input  logic      miso
);

    // Queue to engine
    spi_byte_t txq_data;
    logic      txq_valid;
    logic      txq_ready;

    // Engine to queue
    spi_byte_t rxq_data;
    logic      rxq_valid;
    logic      rxq_ready;

    byte_fifo #(.DEPTH(`SPI_FIFO_DEPTH)) tx_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .in_data  (tx_data),
        .in_valid (tx_valid),
        .in_ready (tx_ready),
        .out_data (txq_data),
        .out_valid(txq_valid),
        .out_ready(txq_ready)
    );

    spi_shift_engine engine (
        .aclk    (aclk),
        .aresetn (aresetn),
        .tx_data (txq_data),
        .tx_valid(txq_valid),
        .tx_ready(txq_ready),
        .rx_data (rxq_data),
        .rx_valid(rxq_valid),
        .rx_ready(rxq_ready),
        .spi     (spi),
        .miso    (miso)
    );

    byte_fifo #(.DEPTH(`SPI_FIFO_DEPTH)) rx_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .in_data  (rxq_data),
        .in_valid (rxq_valid),
        .in_ready (rxq_ready),
        .out_data (rx_data),
        .out_valid(rx_valid),
        .out_ready(rx_ready)
    );

endmodule

`default_nettype wire

//--- verif/spi_master_assertions.sv
/* SPI pin protocol checks for the shift engine
   SCK idle level, MOSI timing, frame length and spacing */

`timescale 1ns/1ns
`include "spi_params.svh"
`default_nettype none

module spi_master_assertions
    import spi_pkg::*;
(
    input logic       aclk,
    input logic       aresetn,
    input spi_pins_t  spi,
    input spi_state_e state
);

    localparam int FRAME_CYCLES = `SPI_PRE_CYCLES + 8 * `SPI_CLK_RATIO + `SPI_POST_CYCLES;

    logic [15:0] low_cnt;
    logic [3:0]  rise_cnt;
    logic        sck_q;

    // Cycles and SCK rising edges of the current frame
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            low_cnt  <= '0;
            rise_cnt <= '0;
            sck_q    <= 1'b0;
        end else begin
            sck_q <= spi.sck;
            if (spi.ss_n) begin
                low_cnt  <= '0;
                rise_cnt <= '0;
            end else begin
                low_cnt <= low_cnt + 1'b1;
                if (spi.sck && !sck_q) begin
                    rise_cnt <= rise_cnt + 1'b1;
                end
            end
        end
    end

    sck_idle_low: assert property (@(posedge aclk) disable iff (!aresetn)
            spi.ss_n |-> !spi.sck)
        else $error("SCK high while slave select is inactive");

    mosi_on_low_sck: assert property (@(posedge aclk) disable iff (!aresetn)
            (spi.mosi != $past(spi.mosi)) |-> !spi.sck)
        else $error("MOSI changed while SCK was high");

    frame_length: assert property (@(posedge aclk) disable iff (!aresetn)
            $rose(spi.ss_n) |-> (low_cnt == 16'(FRAME_CYCLES)))
        else $error("Mismatch low_cnt: expected %h, actual %h", FRAME_CYCLES, $sampled(low_cnt));

    frame_edges: assert property (@(posedge aclk) disable iff (!aresetn)
            $rose(spi.ss_n) |-> (rise_cnt == 4'd8))
        else $error("Mismatch rise_cnt: expected %h, actual %h", 4'd8, $sampled(rise_cnt));

    // ss_n high exactly while the engine idles between frames
    frame_spacing: assert property (@(posedge aclk) disable iff (!aresetn)
            spi.ss_n == (state == IDLE))
        else $error("Slave select level does not match the idle state");

endmodule

bind spi_shift_engine spi_master_assertions pin_checks (
    .aclk   (aclk),
    .aresetn(aresetn),
    .spi    (spi),
    .state  (state)
);

`default_nettype wire

//--- verif/tb_spi_master.sv
/* Testbench for the SPI master subsystem
   Echo slave on the pins, random bytes and drain, checks by assertions */

`timescale 1ns/1ns
`include "spi_params.svh"
`default_nettype none

module tb_spi_master
    import spi_pkg::*;
();

    localparam int NUM_BYTES      = 40;
    localparam int FIRST_BYTES    = 20;
    localparam int FRAME_CYCLES   = `SPI_PRE_CYCLES + 8 * `SPI_CLK_RATIO + `SPI_POST_CYCLES;
    localparam int STALL_CYCLES   = 2 * FRAME_CYCLES + 8;
    localparam int TIMEOUT_CYCLES = 100 * NUM_BYTES + 1000;

    logic        aclk;
    logic        aresetn;
    spi_byte_t   tx_data;
    logic        tx_valid;
    logic        tx_ready;
    spi_byte_t   rx_data;
    logic        rx_valid;
    logic        rx_ready;
    spi_pins_t   spi;
    logic        miso;

    logic [31:0] data_rng;
    logic [31:0] drain_rng;
    logic        drain_hold;
    spi_byte_t   sent_mem [64];
    int          sent_cnt;
    int          chk_cnt;
    int          cycle_cnt;
    spi_byte_t   exp_head;
    int          held_frames;
    logic        ss_n_seen;

    // Echo slave state
    spi_pins_t   pins_prev;
    spi_byte_t   slave_out;
    spi_byte_t   slave_in;
    spi_byte_t   slave_last;

    spi_master_sub dut0 (
        .aclk    (aclk),
        .aresetn (aresetn),
        .tx_data (tx_data),
        .tx_valid(tx_valid),
        .tx_ready(tx_ready),
        .rx_data (rx_data),
        .rx_valid(rx_valid),
        .rx_ready(rx_ready),
        .spi     (spi),
        .miso    (miso)
    );

    always #2 aclk = ~aclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "Simulation stopped on a failed check");
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_byte(input spi_byte_t b);
        tx_data  = b;
        tx_valid = 1'b1;
        while (!tx_ready) begin
            @(negedge aclk);
        end
        @(negedge aclk);
        tx_valid = 1'b0;
    endtask

    task automatic send_random_byte();
        data_rng = xorshift32(data_rng);
        send_byte(data_rng[7:0]);
    endtask

    // ------------------------------------------------------------------------
    // Echo slave, mode 0, returns the previous frame's byte
    // ------------------------------------------------------------------------
    always @(negedge aclk) begin : echo_slave
        spi_byte_t out_next;
        out_next = slave_out;
        if (!spi.ss_n && pins_prev.ss_n) begin
            out_next = slave_last;
        end else if (!spi.sck && pins_prev.sck) begin
            out_next = {slave_out[6:0], 1'b0};
        end
        if (spi.sck && !pins_prev.sck) begin
            slave_in = {slave_in[6:0], spi.mosi};
        end
        if (spi.ss_n && !pins_prev.ss_n) begin
            slave_last = slave_in;
        end
        slave_out = out_next;
        miso      = !spi.ss_n && out_next[7];
        pins_prev = spi;
    end

    // Random drain, forced low while the receive side is held
    always @(negedge aclk) begin
        drain_rng = xorshift32(drain_rng);
        rx_ready  = !drain_hold && (drain_rng[3:2] != 2'b00);
    end

    // Frames started while the receive side is held
    always @(negedge aclk) begin
        if (drain_hold && ss_n_seen && !spi.ss_n) begin
            held_frames = held_frames + 1;
        end
        ss_n_seen = spi.ss_n;
    end

    // Sent bytes and returned byte count
    always @(posedge aclk) begin
        if (aresetn && tx_valid && tx_ready) begin
            sent_mem[sent_cnt[5:0]] = tx_data;
            sent_cnt = sent_cnt + 1;
        end
        if (aresetn && rx_valid && rx_ready) begin
            chk_cnt = chk_cnt + 1;
        end
    end

    // First frame returns the slave's preload
    always_comb begin
        if (chk_cnt == 0) begin
            exp_head = 8'h3c;
        end else begin
            exp_head = sent_mem[6'(chk_cnt - 1)];
        end
    end

    always @(posedge aclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run("Timeout: not every byte came back within the cycle limit");
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    reset_state: assert property (@(posedge aclk)
            $rose(aresetn) |-> (spi.ss_n && !spi.sck && !rx_valid && tx_ready))
        else fail_run($sformatf("Mismatch reset state: ss_n %h sck %h rx_valid %h tx_ready %h",
            $sampled(spi.ss_n), $sampled(spi.sck), $sampled(rx_valid), $sampled(tx_ready)));

    rx_echo: assert property (@(posedge aclk) disable iff (!aresetn)
            (rx_valid && rx_ready) |-> (rx_data == exp_head))
        else fail_run($sformatf("Mismatch rx_data: expected %h, actual %h",
            $sampled(exp_head), $sampled(rx_data)));

    initial begin : stimulus
        spi_byte_t held_byte;
        aclk        = 1'b0;
        aresetn     = 1'b0;
        tx_data     = '0;
        tx_valid    = 1'b0;
        rx_ready    = 1'b0;
        miso        = 1'b0;
        data_rng    = 32'h95cd;
        drain_rng   = xorshift32(32'h95cd);
        drain_hold  = 1'b0;
        sent_cnt    = 0;
        chk_cnt     = 0;
        cycle_cnt   = 0;
        held_frames = 0;
        ss_n_seen   = 1'b1;
        pins_prev   = '{sck: 1'b0, ss_n: 1'b1, mosi: 1'b0};
        slave_out   = '0;
        slave_in    = '0;
        slave_last  = 8'h3c;
        repeat (5) @(negedge aclk);
        aresetn = 1'b1;

        // Back-to-back bytes
        repeat (FIRST_BYTES) send_random_byte();

        // Hold the receive side once the system is empty
        while (chk_cnt != sent_cnt) begin
            @(negedge aclk);
        end
        @(posedge aclk);
        drain_hold = 1'b1;
        @(negedge aclk);
        repeat (2 * `SPI_FIFO_DEPTH) send_random_byte();

        // Both FIFOs full, the next byte has to wait
        data_rng  = xorshift32(data_rng);
        held_byte = data_rng[7:0];
        tx_data   = held_byte;
        tx_valid  = 1'b1;
        repeat (STALL_CYCLES) begin
            assert (!tx_ready)
                else fail_run($sformatf("Mismatch tx_ready: expected 0, actual %h", tx_ready));
            @(negedge aclk);
        end
        assert (spi.ss_n && rx_valid)
            else fail_run("Frames kept running with the receive side held");
        assert (held_frames == `SPI_FIFO_DEPTH)
            else fail_run($sformatf("Mismatch held_frames: expected %h, actual %h",
                `SPI_FIFO_DEPTH, held_frames));
        @(posedge aclk);
        drain_hold = 1'b0;
        @(negedge aclk);
        send_byte(held_byte);

        repeat (NUM_BYTES - FIRST_BYTES - 2 * `SPI_FIFO_DEPTH - 1) send_random_byte();
        while (chk_cnt != NUM_BYTES) begin
            @(negedge aclk);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hw
hw/spi_pkg.sv
hw/byte_fifo.sv
hw/spi_shift_engine.sv
hw/spi_master_sub.sv
verif/spi_master_assertions.sv
verif/tb_spi_master.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SPI master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f flist.f \
    --top-module tb_spi_master \
    -o sim_tb_spi_master

./obj_dir/sim_tb_spi_master
